/* build.f */
common/ifu_addr_pkg.sv
common/ifu_ctrl_pkg.sv
common/fetch_if.sv
rtl/pc_select.sv
prefetch/fetch_fifo.sv
prefetch/prefetch_buffer.sv
rtl/if_id_stage.sv
rtl/ifu_top.sv
verif/tb_instr_mem.sv
verif/tb_ifu.sv

/* Makefile */
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_ifu
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_ifu.sv */
////////////////////////////////////////////////////////////////////////////
// fetch stage testbench
// boot, sequential stream, every redirect kind, ID stalls and bus errors
////////////////////////////////////////////////////////////////////////////

module tb_ifu;
  timeunit 1ns;
  timeprecision 1ps;
  import ifu_ctrl_pkg::*;

  // reference address rules and memory pattern
  localparam logic [31:0] BOOT_BASE  = 32'h0000_2000;
  localparam logic [31:0] MTVEC      = 32'h0000_4001;
  localparam logic [31:0] JUMP_PC    = 32'h0000_5000;
  localparam logic [31:0] MEPC       = 32'h0000_6000;
  localparam logic [31:0] DEPC       = 32'h0000_7000;
  localparam logic [31:0] HALT_PC    = 32'h1A11_0800;
  localparam logic [31:0] DBG_EXC_PC = 32'h1A11_0808;
  localparam logic [31:0] DATA_KEY   = 32'h5a5a_0000;
  localparam logic [31:0] ERR_BASE   = 32'h0000_20c0;
  localparam int unsigned RST_CYCLES = 16;
  // 24 plain, 40 stalled, then two rounds of eight redirects with eight words
  localparam int unsigned TEST_INSTRS  = 192;
  localparam int unsigned MAX_INSTR_NS = 200;
  localparam int unsigned WATCHDOG_NS  = RST_CYCLES * 4 + TEST_INSTRS * MAX_INSTR_NS;
  localparam pc_sel_e     REDIR_SEL [8] = '{PC_JUMP, PC_EXC, PC_EXC, PC_EXC,
                                            PC_EXC, PC_ERET, PC_DRET, PC_BOOT};
  localparam exc_pc_sel_e REDIR_EXC [8] = '{EXC_PC_EXC, EXC_PC_EXC, EXC_PC_IRQ, EXC_PC_DBD,
                                            EXC_PC_DBG_EXC, EXC_PC_EXC, EXC_PC_EXC, EXC_PC_EXC};

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        req_i;
  logic        pc_set_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  irq_id_t     irq_id_i;
  logic [31:0] boot_addr_i;
  logic [31:0] branch_target_i;
  logic [31:0] csr_mepc_i;
  logic [31:0] csr_depc_i;
  logic [31:0] csr_mtvec_i;
  logic        id_in_ready_i;
  logic        instr_valid_clear_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        instr_err_i;
  logic        csr_mtvec_init_o;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  logic [31:0] instr_rdata_id_o;
  logic        instr_fetch_err_o;
  logic [31:0] pc_id_o;
  logic [31:0] pc_if_o;
  logic        pc_mismatch_alert_o;
  logic        if_busy_o;

  // stimulus and reference model state
  integer      seed;
  logic [31:0] rnd;
  logic        stall_en;
  int unsigned err_cnt = 0;
  int unsigned instr_cnt = 0;
  logic [31:0] exp_pc;
  logic        exp_init;
  logic        booted;
  logic        skip_next;
  logic        boot_gnt_pend;
  int          bus_out;
  logic        ready_q;
  logic [31:0] pc_q;
  logic [31:0] pc_if_q;
  logic [31:0] rdata_q;
  logic        ferr_q;

  ifu_top u_ifu_top (.*);

  tb_instr_mem #(.SEED(32'h8eec_9fbb)) u_instr_mem (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i),
    .err_o    (instr_err_i)
  );

  always #2 clk_i = ~clk_i;

  // word the memory returns for a fetch address
  function automatic logic [31:0] expected_word(logic [31:0] pc);
    return {2'b00, pc[31:2]} ^ DATA_KEY;
  endfunction

  function automatic logic in_err_window(logic [31:0] pc);
    return pc[31:4] == ERR_BASE[31:4];
  endfunction

  // first pc after a redirect
  function automatic logic [31:0] redirect_target(pc_sel_e sel, exc_pc_sel_e exc,
                                                  logic [4:0] irq);
    logic [31:0] vec;
    logic [31:0] tgt;
    vec = {MTVEC[31:8], 8'h00};
    case (sel)
      PC_JUMP: tgt = JUMP_PC;
      PC_ERET: tgt = MEPC;
      PC_DRET: tgt = DEPC;
      PC_EXC: begin
        case (exc)
          EXC_PC_IRQ:     tgt = vec + {25'd0, irq, 2'b00};
          EXC_PC_DBD:     tgt = HALT_PC;
          EXC_PC_DBG_EXC: tgt = DBG_EXC_PC;
          default:        tgt = vec;
        endcase
      end
      default: tgt = {BOOT_BASE[31:8], 8'h80};
    endcase
    return tgt;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
    err_cnt++;
    $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic report_problem(string msg);
    err_cnt++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // one-cycle pc_set with a fresh interrupt number
  task automatic redirect(pc_sel_e sel, exc_pc_sel_e exc);
    logic [31:0] r;
    r = $random(seed);
    @(posedge clk_i);
    pc_set_i     <= 1'b1;
    pc_mux_i     <= sel;
    exc_pc_mux_i <= exc;
    irq_id_i     <= r[4:0];
    req_i        <= 1'b1;
    @(posedge clk_i);
    pc_set_i <= 1'b0;
  endtask

  task automatic await_instrs(int unsigned n);
    int unsigned target;
    target = instr_cnt + n;
    while (instr_cnt < target) @(posedge clk_i);
  endtask

  // ID side, random stalls once enabled; it retires what it takes
  always @(posedge clk_i) begin
    rnd = $random(seed);
    id_in_ready_i       <= !stall_en || rnd[0];
    instr_valid_clear_i <= !stall_en || rnd[0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      assert (!(instr_req_o || instr_valid_id_o || instr_new_id_o || pc_mismatch_alert_o ||
                if_busy_o || csr_mtvec_init_o || instr_fetch_err_o))
        else report_problem("a control output is high during reset");
      bus_out       = 0;
      booted        = 1'b0;
      skip_next     = 1'b0;
      boot_gnt_pend = 1'b0;
      exp_pc        = '0;
    end else begin
      exp_init = pc_set_i && (pc_mux_i == PC_BOOT);
      assert (csr_mtvec_init_o == exp_init)
        else report_mismatch("csr_mtvec_init_o", 32'(exp_init), 32'(csr_mtvec_init_o));
      assert (!pc_mismatch_alert_o) else report_problem("pc mismatch alert raised");
      assert (bus_out == 0 || if_busy_o)
        else report_problem("if_busy_o low while a granted request waits for data");
      // bus side bookkeeping
      if (instr_req_o && instr_gnt_i) begin
        if (boot_gnt_pend) begin
          assert (instr_addr_o == redirect_target(PC_BOOT, EXC_PC_EXC, 5'd0))
            else report_mismatch("instr_addr_o",
                                 redirect_target(PC_BOOT, EXC_PC_EXC, 5'd0), instr_addr_o);
          boot_gnt_pend = 1'b0;
        end
        assert (bus_out < 2) else report_problem("more than two requests outstanding");
        bus_out++;
      end
      if (instr_rvalid_i) begin
        bus_out--;
      end
      // ID outputs frozen after a stalled cycle
      if (!ready_q) begin
        assert (!instr_new_id_o) else report_problem("new instruction while ID stalled");
        assert (pc_id_o == pc_q) else report_mismatch("pc_id_o", pc_q, pc_id_o);
        assert (instr_rdata_id_o == rdata_q)
          else report_mismatch("instr_rdata_id_o", rdata_q, instr_rdata_id_o);
        assert (instr_fetch_err_o == ferr_q)
          else report_mismatch("instr_fetch_err_o", 32'(ferr_q), 32'(instr_fetch_err_o));
      end
      // a word taken in the pc_set cycle is from the old stream
      if (instr_new_id_o && !skip_next) begin
        assert (booted) else report_problem("instruction arrived before boot");
        assert (pc_id_o == exp_pc) else report_mismatch("pc_id_o", exp_pc, pc_id_o);
        // the IF side showed the same address one cycle earlier
        assert (pc_if_q == exp_pc) else report_mismatch("pc_if_o", exp_pc, pc_if_q);
        assert (instr_rdata_id_o == expected_word(exp_pc))
          else report_mismatch("instr_rdata_id_o", expected_word(exp_pc), instr_rdata_id_o);
        assert (instr_fetch_err_o == in_err_window(exp_pc))
          else report_mismatch("instr_fetch_err_o", 32'(in_err_window(exp_pc)),
                               32'(instr_fetch_err_o));
        assert (instr_valid_id_o) else report_problem("instr_valid_id_o low on a new word");
        exp_pc = exp_pc + 32'd4;
        instr_cnt++;
      end
      skip_next = pc_set_i;
      if (pc_set_i) begin
        exp_pc = redirect_target(pc_mux_i, exc_pc_mux_i, irq_id_i);
        boot_gnt_pend = !booted;
        booted = 1'b1;
      end
    end
    ready_q = id_in_ready_i;
    pc_q    = pc_id_o;
    pc_if_q = pc_if_o;
    rdata_q = instr_rdata_id_o;
    ferr_q  = instr_fetch_err_o;
  end

  initial begin
    seed                = 32'h8eec_9fbb;
    stall_en            <= 1'b0;
    rst_ni              <= 1'b0;
    req_i               <= 1'b0;
    pc_set_i            <= 1'b0;
    pc_mux_i            <= PC_BOOT;
    exc_pc_mux_i        <= EXC_PC_EXC;
    irq_id_i            <= '0;
    boot_addr_i         <= BOOT_BASE;
    branch_target_i     <= JUMP_PC;
    csr_mepc_i          <= MEPC;
    csr_depc_i          <= DEPC;
    csr_mtvec_i         <= MTVEC;
    id_in_ready_i       <= 1'b1;
    instr_valid_clear_i <= 1'b1;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);
    // boot and run through the error window
    redirect(PC_BOOT, EXC_PC_EXC);
    await_instrs(24);
    stall_en <= 1'b1;
    await_instrs(40);
    // every redirect kind, first without and then with stalls
    for (int round = 0; round < 2; round++) begin
      stall_en <= (round == 1);
      for (int i = 0; i < 8; i++) begin
        redirect(REDIR_SEL[i], REDIR_EXC[i]);
        await_instrs(8);
      end
    end
    $display("tb_ifu done: %0d instructions checked, %0d errors", instr_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // run length bound from instruction count
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired with %0d of %0d instructions done", instr_cnt, TEST_INSTRS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* verif/tb_instr_mem.sv */
////////////////////////////////////////////////////////////////////////////
// instruction bus responder
// random grants and in-order responses with random delay, one error window
////////////////////////////////////////////////////////////////////////////

module tb_instr_mem #(
  parameter logic [31:0] SEED = 32'h8eec_9fbb
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // data pattern and the 16 byte window that answers with a bus error
  localparam logic [31:0] DATA_KEY = 32'h5a5a_0000;
  localparam logic [31:0] ERR_BASE = 32'h0000_20c0;

  integer      seed;
  logic [31:0] rnd;
  logic [31:0] head;
  // granted addresses waiting for their response, oldest first
  logic [31:0] pend_q [$];

  initial begin
    seed = SEED;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      pend_q.delete();
    end else begin
      rnd = $random(seed);
      // request accepted in the cycle that just ended
      if (req_i && gnt_o) begin
        pend_q.push_back(addr_i);
      end
      // grant about three cycles in four
      gnt_o <= (rnd[1:0] != 2'b00);
      // earliest response is the cycle after the grant
      if ((pend_q.size() != 0) && (rnd[3:2] != 2'b00)) begin
        head = pend_q.pop_front();
        rvalid_o <= 1'b1;
        rdata_o  <= {2'b00, head[31:2]} ^ DATA_KEY;
        err_o    <= (head[31:4] == ERR_BASE[31:4]);
      end else begin
        rvalid_o <= 1'b0;
        rdata_o  <= '0;
        err_o    <= 1'b0;
      end
    end
  end

endmodule

/* rtl/ifu_top.sv */
////////////////////////////////////////////////////////////////////////////
// instruction fetch stage
// pc selection, prefetch buffer on the instruction bus, IF-ID register
////////////////////////////////////////////////////////////////////////////

module ifu_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  ifu_addr_pkg::addr_t       boot_addr_i,
  input  logic                      req_i,
  // instruction bus
  output logic                      instr_req_o,
  output ifu_addr_pkg::addr_t       instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  ifu_addr_pkg::instr_t      instr_rdata_i,
  input  logic                      instr_err_i,
  // redirect control
  input  logic                      pc_set_i,
  input  ifu_ctrl_pkg::pc_sel_e     pc_mux_i,
  input  ifu_ctrl_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  ifu_ctrl_pkg::irq_id_t     irq_id_i,
  input  ifu_addr_pkg::addr_t       branch_target_i,
  // csr values
  input  ifu_addr_pkg::addr_t       csr_mepc_i,
  input  ifu_addr_pkg::addr_t       csr_depc_i,
  input  ifu_addr_pkg::addr_t       csr_mtvec_i,
  output logic                      csr_mtvec_init_o,
  // ID side
  input  logic                      id_in_ready_i,
  input  logic                      instr_valid_clear_i,
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output ifu_addr_pkg::instr_t      instr_rdata_id_o,
  output logic                      instr_fetch_err_o,
  output ifu_addr_pkg::addr_t       pc_id_o,
  output ifu_addr_pkg::addr_t       pc_if_o,
  // status
  output logic                      pc_mismatch_alert_o,
  output logic                      if_busy_o
);
  import ifu_addr_pkg::*;

  addr_t fetch_addr;

  // fetched words between buffer and ID register
  fetch_if u_fetch ();

  pc_select u_pc_select (
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .irq_id_i        (irq_id_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_depc_i      (csr_depc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .pc_set_i        (pc_set_i),
    .fetch_addr_o    (fetch_addr),
    .mtvec_init_o    (csr_mtvec_init_o)
  );

  // every pc_set redirects the buffer
  prefetch_buffer u_prefetch_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .branch_addr_i  (fetch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .out_o          (u_fetch.src),
    .busy_o         (if_busy_o)
  );

  if_id_stage u_if_id_stage (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pc_set_i            (pc_set_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .in_i                (u_fetch.dst),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

/* rtl/if_id_stage.sv */
////////////////////////////////////////////////////////////////////////////
// IF-ID pipeline register
// valid and new flags, bus error forwarding, sequential pc check
////////////////////////////////////////////////////////////////////////////

module if_id_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 pc_set_i,
  input  logic                 id_in_ready_i,
  input  logic                 instr_valid_clear_i,
  fetch_if.dst                 in_i,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output ifu_addr_pkg::instr_t instr_rdata_id_o,
  output logic                 instr_fetch_err_o,
  output ifu_addr_pkg::addr_t  pc_id_o,
  output ifu_addr_pkg::addr_t  pc_if_o,
  output logic                 pc_mismatch_alert_o
);
  import ifu_addr_pkg::*;

  logic  xfer;
  logic  seq_q;
  logic  seq_d;
  addr_t pc_next;

  // ID stall backs straight up into the FIFO
  assign in_i.ready = id_in_ready_i;
  assign xfer       = in_i.valid & id_in_ready_i;
  assign pc_if_o    = in_i.addr;

  // armed after a transfer; redirects and bus errors break the sequence
  assign seq_d = (seq_q | xfer) & ~pc_set_i & ~(in_i.valid & in_i.err);

  // incoming word should sit right after the one in ID
  assign pc_next             = pc_id_o + addr_t'(INSTR_BYTES);
  assign pc_mismatch_alert_o = seq_q & in_i.valid & (in_i.addr != pc_next);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o  <= 1'b0;
      instr_new_id_o    <= 1'b0;
      instr_fetch_err_o <= 1'b0;
      seq_q             <= 1'b0;
    end else begin
      // a word taken during pc_set is squashed
      // valid holds until the core retires or kills it
      instr_valid_id_o <= (xfer & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);
      instr_new_id_o   <= xfer;
      seq_q            <= seq_d;
      if (xfer) begin
        instr_fetch_err_o <= in_i.err;
      end
    end
  end

  // payload frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      instr_rdata_id_o <= in_i.rdata;
      pc_id_o          <= in_i.addr;
    end
  end

endmodule

/* prefetch/prefetch_buffer.sv */
////////////////////////////////////////////////////////////////////////////
// prefetch buffer
// instruction bus master with up to two requests in flight; responses land
// in a small FIFO, and a branch flushes it and drops stale responses
////////////////////////////////////////////////////////////////////////////

module prefetch_buffer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 branch_i,
  input  ifu_addr_pkg::addr_t  branch_addr_i,
  output logic                 instr_req_o,
  output ifu_addr_pkg::addr_t  instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  ifu_addr_pkg::instr_t instr_rdata_i,
  input  logic                 instr_err_i,
  fetch_if.src                 out_o,
  output logic                 busy_o
);
  import ifu_addr_pkg::*;
  import ifu_ctrl_pkg::*;

  addr_t     branch_addr;
  addr_t     fetch_addr_q;
  addr_t     rsp_addr_q;
  addr_t     pend_addr_q;
  fifo_cnt_t free;
  fifo_cnt_t out_cnt_q;
  fifo_cnt_t out_cnt_d;
  fifo_cnt_t disc_cnt_q;
  fifo_cnt_t disc_cnt_d;
  logic      req_pend_q;
  logic      stale_q;
  logic      stale_d;
  logic      can_issue;
  logic      discard;
  logic      fifo_push;

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  assign branch_addr = {branch_addr_i[31:2], 2'b00};

  // every request in flight owns a free FIFO slot
  assign can_issue = (out_cnt_q < free) && (out_cnt_q < fifo_cnt_t'(MAX_OUTSTANDING));

  // an ungranted request stays up; a fresh one waits a cycle after a branch
  assign instr_req_o = req_pend_q | (req_i & can_issue & ~branch_i);

  // a request caught by a branch keeps its old address until granted
  assign instr_addr_o = stale_q ? pend_addr_q : fetch_addr_q;
  assign stale_d      = (stale_q | branch_i) & instr_req_o & ~instr_gnt_i;

  assign busy_o = instr_req_o | (out_cnt_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////////////////////

  // oldest responses after a branch belong to the old stream
  assign discard   = instr_rvalid_i & ((disc_cnt_q != '0) | branch_i);
  assign fifo_push = instr_rvalid_i & ~discard;

  assign out_cnt_d = out_cnt_q + fifo_cnt_t'(instr_req_o & instr_gnt_i)
                   - fifo_cnt_t'(instr_rvalid_i);

  always_comb begin
    disc_cnt_d = disc_cnt_q;
    if (branch_i) begin
      // everything still in flight is stale
      disc_cnt_d = out_cnt_d;
    end else begin
      if (instr_rvalid_i && (disc_cnt_q != '0)) begin
        disc_cnt_d = disc_cnt_d - fifo_cnt_t'(1);
      end
      // stale request granted late, its response goes too
      if (stale_q && instr_gnt_i) begin
        disc_cnt_d = disc_cnt_d + fifo_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_pend_q   <= 1'b0;
      stale_q      <= 1'b0;
      out_cnt_q    <= '0;
      disc_cnt_q   <= '0;
      fetch_addr_q <= '0;
      rsp_addr_q   <= '0;
    end else begin
      req_pend_q <= instr_req_o & ~instr_gnt_i;
      stale_q    <= stale_d;
      out_cnt_q  <= out_cnt_d;
      disc_cnt_q <= disc_cnt_d;
      // next address to request
      if (branch_i) begin
        fetch_addr_q <= branch_addr;
      end else if (instr_req_o && instr_gnt_i && !stale_q) begin
        fetch_addr_q <= fetch_addr_q + addr_t'(INSTR_BYTES);
      end
      // address of the next kept response
      if (branch_i) begin
        rsp_addr_q <= branch_addr;
      end else if (fifo_push) begin
        rsp_addr_q <= rsp_addr_q + addr_t'(INSTR_BYTES);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_req_o && !instr_gnt_i) begin
      pend_addr_q <= instr_addr_o;
    end
  end

  fetch_fifo u_fetch_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (branch_i),
    .in_valid_i (fifo_push),
    .in_rdata_i (instr_rdata_i),
    .in_err_i   (instr_err_i),
    .in_addr_i  (rsp_addr_q),
    .free_o     (free),
    .out_o      (out_o)
  );

  // bus address usable and word aligned
  req_addr_ok_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> !$isunknown(instr_addr_o) && (instr_addr_o[1:0] == 2'b00));

  // request held with a stable address until granted
  req_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  out_cnt_max_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_cnt_q <= fifo_cnt_t'(MAX_OUTSTANDING));

endmodule

/* prefetch/fetch_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// fetch FIFO
// circular queue of fetched words with address and bus error flag
////////////////////////////////////////////////////////////////////////////

module fetch_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    in_valid_i,
  input  ifu_addr_pkg::instr_t    in_rdata_i,
  input  logic                    in_err_i,
  input  ifu_addr_pkg::addr_t     in_addr_i,
  output ifu_ctrl_pkg::fifo_cnt_t free_o,
  fetch_if.src                    out_o
);
  import ifu_addr_pkg::*;
  import ifu_ctrl_pkg::*;

  localparam fifo_cnt_t DEPTH_CNT = fifo_cnt_t'(FIFO_DEPTH);
  localparam fifo_cnt_t LAST_IDX  = fifo_cnt_t'(FIFO_DEPTH - 1);

  instr_t    rdata_q [FIFO_DEPTH];
  addr_t     addr_q  [FIFO_DEPTH];
  logic      err_q   [FIFO_DEPTH];
  fifo_cnt_t wr_ptr_q;
  fifo_cnt_t rd_ptr_q;
  fifo_cnt_t cnt_q;
  logic      pop;

  // pointers wrap at the last entry
  function automatic fifo_cnt_t ptr_inc(fifo_cnt_t ptr);
    return (ptr == LAST_IDX) ? '0 : ptr + fifo_cnt_t'(1);
  endfunction

  assign pop = out_o.valid & out_o.ready;

  // head entry straight from storage
  assign out_o.valid = (cnt_q != '0);
  assign out_o.rdata = rdata_q[rd_ptr_q];
  assign out_o.addr  = addr_q[rd_ptr_q];
  assign out_o.err   = err_q[rd_ptr_q];

  assign free_o = DEPTH_CNT - cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      // flush on redirect
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (in_valid_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      cnt_q <= cnt_q + fifo_cnt_t'(in_valid_i) - fifo_cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      rdata_q[wr_ptr_q] <= in_rdata_i;
      addr_q[wr_ptr_q]  <= in_addr_i;
      err_q[wr_ptr_q]   <= in_err_i;
    end
  end

  // buffer only requests when a slot is reserved, so never overflows
  no_write_full_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_i |-> cnt_q != DEPTH_CNT);

  // waiting head word holds unless flushed
  out_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_o.valid && !out_o.ready && !clear_i |=>
      out_o.valid && $stable(out_o.addr) && $stable(out_o.rdata));

endmodule

/* rtl/pc_select.sv */
////////////////////////////////////////////////////////////////////////////
// next pc selection
// builds the trap vector from mtvec or the debug entries and picks the
// address that the prefetch buffer loads on pc_set
////////////////////////////////////////////////////////////////////////////

module pc_select (
  input  ifu_ctrl_pkg::pc_sel_e     pc_mux_i,
  input  ifu_ctrl_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  ifu_ctrl_pkg::irq_id_t     irq_id_i,
  input  ifu_addr_pkg::addr_t       boot_addr_i,
  input  ifu_addr_pkg::addr_t       branch_target_i,
  input  ifu_addr_pkg::addr_t       csr_mepc_i,
  input  ifu_addr_pkg::addr_t       csr_depc_i,
  input  ifu_addr_pkg::addr_t       csr_mtvec_i,
  input  logic                      pc_set_i,
  output ifu_addr_pkg::addr_t       fetch_addr_o,
  output logic                      mtvec_init_o
);
  import ifu_addr_pkg::*;
  import ifu_ctrl_pkg::*;

  addr_t vec_base;
  addr_t boot_pc;
  addr_t exc_pc;

  // mtvec mode bits and low offset are dropped
  assign vec_base = {csr_mtvec_i[31:VEC_BASE_LSB], {VEC_BASE_LSB{1'b0}}};
  assign boot_pc  = {boot_addr_i[31:$bits(BOOT_OFFSET)], BOOT_OFFSET};

  // trap vector
  always_comb begin : exc_pc_mux
    unique case (exc_pc_mux_i)
      // vectored interrupts, one word per irq line
      EXC_PC_IRQ:     exc_pc = vec_base + addr_t'(irq_id_i) * addr_t'(INSTR_BYTES);
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = vec_base;
    endcase
  end

  // fetch address
  always_comb begin : fetch_addr_mux
    unique case (pc_mux_i)
      PC_JUMP: fetch_addr_o = branch_target_i;
      PC_EXC:  fetch_addr_o = exc_pc;
      PC_ERET: fetch_addr_o = csr_mepc_i;
      PC_DRET: fetch_addr_o = csr_depc_i;
      default: fetch_addr_o = boot_pc;
    endcase
  end

  // csr file initialises mtvec from the boot address on the boot jump
  assign mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  // selector must be defined whenever the core redirects fetch
  always_comb begin
    if (pc_set_i) begin
      assert (!$isunknown(pc_mux_i)) else $error("pc_mux_i unknown on pc_set");
      if (pc_mux_i == PC_BOOT) begin
        assert (boot_addr_i[7:0] == 8'h00) else $error("boot base not 256 byte aligned");
      end
    end
  end

endmodule

/* common/fetch_if.sv */
////////////////////////////////////////////////////////////////////////////
// fetched word channel, prefetch buffer to IF-ID register
////////////////////////////////////////////////////////////////////////////

interface fetch_if;
  import ifu_addr_pkg::*;

  // valid/ready handshake, a word moves when both are high
  logic   valid;
  logic   ready;
  // payload, held stable while valid waits for ready
  instr_t rdata;
  addr_t  addr;
  logic   err;

  modport src (
    output valid, rdata, addr, err,
    input  ready
  );

  modport dst (
    input  valid, rdata, addr, err,
    output ready
  );

endinterface

/* common/ifu_ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// fetch stage control package
// pc and exception vector selectors, interrupt id, bus and FIFO depths
////////////////////////////////////////////////////////////////////////////

package ifu_ctrl_pkg;

  // source of the next fetch address on pc_set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // which trap vector feeds PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // interrupt number for vectored mode
  typedef logic [4:0] irq_id_t;

  // bus requests in flight at most
  localparam int unsigned MAX_OUTSTANDING = 2;
  // one more slot than requests, so a stalled output never blocks a response
  localparam int unsigned FIFO_DEPTH = MAX_OUTSTANDING + 1;

  // FIFO occupancy, free slots and outstanding request count
  typedef logic [1:0] fifo_cnt_t;

endpackage

/* common/ifu_addr_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// fetch stage address package
// byte address and instruction word types, debug entry points, boot offset
////////////////////////////////////////////////////////////////////////////

package ifu_addr_pkg;

  // byte address on the instruction bus
  typedef logic [31:0] addr_t;
  // one uncompressed instruction word
  typedef logic [31:0] instr_t;

  // debug module entry points
  localparam addr_t DM_HALT_ADDR = 32'h1A11_0800;
  localparam addr_t DM_EXC_ADDR  = 32'h1A11_0808;

  // boot pc sits at this offset from the 256 byte aligned boot base
  localparam logic [7:0] BOOT_OFFSET = 8'h80;

  // mtvec bits below this one are forced to zero in the vector base
  localparam int unsigned VEC_BASE_LSB = 8;

  // no compressed instructions, so the pc always steps a full word
  localparam int unsigned INSTR_BYTES = 4;

endpackage
